// File: logic/neoPkg.sv
package neoPkg;

  // frame buffer geometry, one configuration only
  localparam int BUFFER_END  = 255;
  localparam int BUFFER_BITS = $clog2(BUFFER_END + 1);

  typedef logic [13:0]            addrT;
  typedef logic [7:0]             byteT;
  typedef logic [BUFFER_BITS-1:0] pixelIxT;
  typedef logic [12:0]            regMaxT;

  // register offsets, decoded from the low address bits when bit 13 is set
  localparam logic [2:0] REG_MAX_LO = 3'd0;
  localparam logic [2:0] REG_MAX_HI = 3'd1;
  localparam logic [2:0] REG_CTRL   = 3'd2;
  localparam logic [2:0] REG_STATE  = 3'd3;

  // pulse timing in busClk cycles
  localparam int T0_HIGH     = 2;
  localparam int T1_HIGH     = 4;
  localparam int T_BIT       = 6;
  localparam int T_LATCH     = 24;
  localparam int INIT_CYCLES = 16;

  typedef struct packed {
    logic init;
    logic limit;
    logic run;
    logic loop;
    logic mode32;
  } ctrlT;

  typedef struct packed {
    logic valid;
    logic last;
    byteT data;
  } byteStrobeT;

  typedef enum logic [2:0] {seqIdle, seqInit, seqFetch, seqWait, seqLatch} seqStateT;

endpackage

// File: logic/neoPixelRam.sv
`timescale 1ns/10ps

module neoPixelRam (
  input  logic            busClk,
  input  logic            we,
  input  neoPkg::pixelIxT wAddr,
  input  neoPkg::byteT    wData,
  input  neoPkg::pixelIxT rAddr,
  output neoPkg::byteT    rData
);
  import neoPkg::*;

  byteT    mem [0:BUFFER_END];
  pixelIxT rAddrQ;

  // bus side write port
  always_ff @(posedge busClk) begin
    if (we) begin
      mem[wAddr] <= wData;
    end
  end

  // the read address is registered, so data trails the address by one cycle
  always_ff @(posedge busClk) begin
    rAddrQ <= rAddr;
  end

  assign rData = mem[rAddrQ];

endmodule

// File: logic/neoRegisters.sv
`timescale 1ns/10ps

module neoRegisters (
  input  logic            busClk,
  input  logic            rstN,
  input  neoPkg::addrT    busAddr,
  input  neoPkg::byteT    busDataIn,
  input  logic            busWrite,
  input  logic            busRead,
  output neoPkg::byteT    busDataOut,
  input  neoPkg::pixelIxT pixelIx,
  output neoPkg::byteT    pixelByte,
  input  logic            syncStart,
  input  logic            frameDone,
  input  logic            initDone,
  input  logic            busy,
  output neoPkg::ctrlT    ctrl,
  output neoPkg::regMaxT  regMax
);
  import neoPkg::*;

  ctrlT    ctrlQ;
  regMaxT  regMaxQ;
  byteT    readData;
  pixelIxT ramWAddr;
  logic    regSel;
  logic    ramWe;

  // address bit 13 splits the map into frame buffer and registers
  assign regSel   = busAddr[13];
  assign ramWe    = busWrite && !regSel;
  assign ramWAddr = busAddr[BUFFER_BITS-1:0];

  neoPixelRam frameBuffer (
    .busClk(busClk),
    .we    (ramWe),
    .wAddr (ramWAddr),
    .wData (busDataIn),
    .rAddr (pixelIx),
    .rData (pixelByte)
  );

  always_ff @(posedge busClk or negedge rstN) begin
    if (!rstN) begin
      ctrlQ   <= '0;
      regMaxQ <= '0;
    end else begin
      // a finished frame stops the strip unless it is looping
      if (frameDone) begin
        ctrlQ.run <= ctrlQ.run && ctrlQ.loop;
      end
      if (syncStart) begin
        ctrlQ.run <= 1'b1;
      end
      if (busWrite && regSel) begin
        case (busAddr[2:0])
          REG_MAX_LO: regMaxQ[7:0]  <= busDataIn;
          REG_MAX_HI: regMaxQ[12:8] <= busDataIn[4:0];
          REG_CTRL: begin
            ctrlQ.init   <= busDataIn[0];
            ctrlQ.limit  <= busDataIn[1];
            ctrlQ.run    <= busDataIn[2];
            ctrlQ.loop   <= busDataIn[3];
            ctrlQ.mode32 <= busDataIn[4];
          end
          default: ;
        endcase
      end
      // init holds every other control bit at zero until the sequencer is done
      if (ctrlQ.init) begin
        ctrlQ.limit  <= 1'b0;
        ctrlQ.run    <= 1'b0;
        ctrlQ.loop   <= 1'b0;
        ctrlQ.mode32 <= 1'b0;
      end
      if (initDone) begin
        ctrlQ.init <= 1'b0;
      end
    end
  end

  // buffer reads are not supported and return all ones
  always_comb begin
    readData = 8'hFF;
    if (regSel) begin
      case (busAddr[2:0])
        REG_MAX_LO: readData = regMaxQ[7:0];
        REG_MAX_HI: readData = {3'b000, regMaxQ[12:8]};
        REG_CTRL: begin
          readData = {3'b000, ctrlQ.mode32, ctrlQ.loop, ctrlQ.run, ctrlQ.limit, ctrlQ.init};
        end
        REG_STATE:  readData = {7'b0000000, busy};
        default:    readData = 8'h00;
      endcase
    end
  end

  always_ff @(posedge busClk) begin
    if (busRead) begin
      busDataOut <= readData;
    end
  end

  assign ctrl   = ctrlQ;
  assign regMax = regMaxQ;

  // the bus master never issues a read and a write in one cycle
  assert property (@(posedge busClk) disable iff (!rstN) !(busWrite && busRead));

endmodule

// File: logic/neoFrameSequencer.sv
`timescale 1ns/10ps

module neoFrameSequencer (
  input  logic               busClk,
  input  logic               rstN,
  input  neoPkg::ctrlT       ctrl,
  input  neoPkg::regMaxT     regMax,
  output neoPkg::pixelIxT    pixelIx,
  input  neoPkg::byteT       pixelByte,
  input  logic               encReady,
  input  logic               latchDone,
  output neoPkg::byteStrobeT txByte,
  output logic               frameDone,
  output logic               initDone,
  output logic               busy
);
  import neoPkg::*;

  seqStateT                       state;
  pixelIxT                        endIx;
  logic [BUFFER_BITS:0]           nextIx;
  logic                           isLast;
  logic [$clog2(INIT_CYCLES)-1:0] initCnt;

  // a limit beyond the buffer is clamped to its last byte
  always_comb begin
    if (ctrl.limit && (regMax < regMaxT'(BUFFER_END))) begin
      endIx = pixelIxT'(regMax);
    end else begin
      endIx = pixelIxT'(BUFFER_END);
    end
  end

  // one extra bit so that stepping past the end of the buffer is visible
  always_comb begin
    nextIx = {1'b0, pixelIx} + 1'b1;
    // in 24-bit mode the fourth byte of every word is padding
    if (!ctrl.mode32 && (nextIx[1:0] == 2'd3)) begin
      nextIx = nextIx + 1'b1;
    end
  end

  assign isLast = nextIx > {1'b0, endIx};

  always_ff @(posedge busClk or negedge rstN) begin
    if (!rstN) begin
      state   <= seqIdle;
      pixelIx <= '0;
      initCnt <= '0;
      txByte  <= '0;
    end else begin
      txByte.valid <= 1'b0;
      case (state)
        seqIdle: begin
          if (ctrl.init) begin
            initCnt <= '0;
            state   <= seqInit;
          end else if (ctrl.run) begin
            pixelIx <= '0;
            state   <= seqFetch;
          end
        end
        seqInit: begin
          initCnt <= initCnt + 1'b1;
          if (initDone) begin
            state <= seqIdle;
          end
        end
        // the buffer needs one cycle to turn the index into data
        seqFetch: state <= seqWait;
        seqWait: begin
          if (encReady) begin
            txByte.valid <= 1'b1;
            txByte.last  <= isLast;
            txByte.data  <= pixelByte;
            if (isLast) begin
              state <= seqLatch;
            end else begin
              pixelIx <= nextIx[BUFFER_BITS-1:0];
              state   <= seqFetch;
            end
          end
        end
        seqLatch: begin
          if (latchDone) begin
            state <= seqIdle;
          end
        end
        default: state <= seqIdle;
      endcase
    end
  end

  // both pulses leave idle with the register side already updated
  assign frameDone = (state == seqLatch) && latchDone;
  assign initDone  = (state == seqInit) && (initCnt == INIT_CYCLES - 1);
  assign busy      = state != seqIdle;

  // the encoder must still be free in the cycle the registered strobe arrives
  assert property (@(posedge busClk) disable iff (!rstN) txByte.valid |-> encReady);

endmodule

// File: logic/neoBitEncoder.sv
`timescale 1ns/10ps

module neoBitEncoder (
  input  logic               busClk,
  input  logic               rstN,
  input  neoPkg::byteStrobeT txByte,
  output logic               encReady,
  output logic               latchDone,
  output logic               neoData
);
  import neoPkg::*;

  byteT                       shiftQ;
  logic                       lastQ;
  logic [2:0]                 bitCnt;
  logic [$clog2(T_LATCH)-1:0] cycCnt;
  logic                       shifting;
  logic                       latching;
  logic                       bitEnd;
  logic                       highNow;
  logic                       take;

  assign encReady = !shifting && !latching;
  assign take     = txByte.valid && encReady;
  assign bitEnd   = cycCnt == T_BIT - 1;
  // the msb decides how long the current bit stays high
  assign highNow  = shifting && (cycCnt < (shiftQ[7] ? T1_HIGH : T0_HIGH));

  always_ff @(posedge busClk) begin
    if (take) begin
      shiftQ <= txByte.data;
      lastQ  <= txByte.last;
    end else if (shifting && bitEnd) begin
      shiftQ <= {shiftQ[6:0], 1'b0};
    end
  end

  always_ff @(posedge busClk or negedge rstN) begin
    if (!rstN) begin
      shifting  <= 1'b0;
      latching  <= 1'b0;
      bitCnt    <= '0;
      cycCnt    <= '0;
      latchDone <= 1'b0;
      neoData   <= 1'b0;
    end else begin
      neoData   <= highNow;
      latchDone <= 1'b0;
      if (take) begin
        shifting <= 1'b1;
        bitCnt   <= 3'd7;
        cycCnt   <= '0;
      end else if (shifting) begin
        if (bitEnd) begin
          cycCnt <= '0;
          bitCnt <= bitCnt - 1'b1;
          if (bitCnt == 3'd0) begin
            shifting <= 1'b0;
            latching <= lastQ;
          end
        end else begin
          cycCnt <= cycCnt + 1'b1;
        end
      end else if (latching) begin
        // the line stays low for the whole gap so the strip latches the frame
        if (cycCnt == T_LATCH - 1) begin
          cycCnt    <= '0;
          latching  <= 1'b0;
          latchDone <= 1'b1;
        end else begin
          cycCnt <= cycCnt + 1'b1;
        end
      end
    end
  end

  assert property (@(posedge busClk) disable iff (!rstN)
    $rose(neoData) |-> ##[1:T1_HIGH] !neoData);

endmodule

// File: logic/neoTop.sv
`timescale 1ns/10ps

module neoTop (
  input  logic         busClk,
  input  logic         rstN,
  input  neoPkg::addrT busAddr,
  input  neoPkg::byteT busDataIn,
  input  logic         busWrite,
  input  logic         busRead,
  output neoPkg::byteT busDataOut,
  input  logic         syncStart,
  output logic         neoData
);
  import neoPkg::*;

  ctrlT       ctrl;
  regMaxT     regMax;
  pixelIxT    pixelIx;
  byteT       pixelByte;
  byteStrobeT txByte;
  logic       frameDone;
  logic       initDone;
  logic       busy;
  logic       encReady;
  logic       latchDone;

  neoRegisters regs (
    .busClk    (busClk),
    .rstN      (rstN),
    .busAddr   (busAddr),
    .busDataIn (busDataIn),
    .busWrite  (busWrite),
    .busRead   (busRead),
    .busDataOut(busDataOut),
    .pixelIx   (pixelIx),
    .pixelByte (pixelByte),
    .syncStart (syncStart),
    .frameDone (frameDone),
    .initDone  (initDone),
    .busy      (busy),
    .ctrl      (ctrl),
    .regMax    (regMax)
  );

  neoFrameSequencer sequencer (
    .busClk   (busClk),
    .rstN     (rstN),
    .ctrl     (ctrl),
    .regMax   (regMax),
    .pixelIx  (pixelIx),
    .pixelByte(pixelByte),
    .encReady (encReady),
    .latchDone(latchDone),
    .txByte   (txByte),
    .frameDone(frameDone),
    .initDone (initDone),
    .busy     (busy)
  );

  neoBitEncoder encoder (
    .busClk   (busClk),
    .rstN     (rstN),
    .txByte   (txByte),
    .encReady (encReady),
    .latchDone(latchDone),
    .neoData  (neoData)
  );

endmodule

// File: verif/neoTb.sv
`timescale 1ns/10ps

module neoTb;
  import neoPkg::*;

  localparam int WAIT_LIMIT = 4000;

  logic        busClk;
  logic        rstN;
  addrT        busAddr;
  byteT        busDataIn;
  logic        busWrite;
  logic        busRead;
  byteT        busDataOut;
  logic        syncStart;
  logic        neoData;
  int          errors;
  int          checks;
  int          highSeen;
  logic [31:0] lfsr;
  byteT        shadow [0:BUFFER_END];
  byteT        gotBytes [$];
  byteT        expBytes [$];
  byteT        firstFrame [$];

  neoTop DUT (
    .busClk    (busClk),
    .rstN      (rstN),
    .busAddr   (busAddr),
    .busDataIn (busDataIn),
    .busWrite  (busWrite),
    .busRead   (busRead),
    .busDataOut(busDataOut),
    .syncStart (syncStart),
    .neoData   (neoData)
  );

  initial busClk = 1'b0;
  always #2 busClk = ~busClk;

  // counts every sampled high cycle on the strip line
  always @(negedge busClk) begin
    if (neoData === 1'b1) begin
      highSeen++;
    end
  end

  function automatic logic nextLfsrBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr   = lfsr >> 1;
    if (outBit) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return outBit;
  endfunction

  function automatic byteT randomByte();
    byteT value;
    for (int i = 0; i < 8; i++) begin
      value = {value[6:0], nextLfsrBit()};
    end
    return value;
  endfunction

  function automatic addrT regAddr(logic [2:0] offset);
    return {1'b1, 10'd0, offset};
  endfunction

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic writeBus(addrT addr, byteT data);
    @(negedge busClk);
    busAddr   = addr;
    busDataIn = data;
    busWrite  = 1'b1;
    @(negedge busClk);
    busWrite  = 1'b0;
  endtask

  // data is registered on the strobe edge and is stable by the next falling edge
  task automatic readBus(input addrT addr, output byteT data);
    @(negedge busClk);
    busAddr = addr;
    busRead = 1'b1;
    @(negedge busClk);
    busRead = 1'b0;
    data    = busDataOut;
  endtask

  task automatic readCheck(addrT addr, byteT exp, string name);
    byteT data;
    readBus(addr, data);
    checkValue(name, data, exp);
  endtask

  task automatic loadBuffer(int count);
    for (int i = 0; i < count; i++) begin
      shadow[i] = randomByte();
      writeBus(addrT'(i), shadow[i]);
    end
  endtask

  // in 24-bit mode every fourth byte of the buffer is padding
  task automatic buildExpected(int lastIx, logic mode32);
    expBytes.delete();
    for (int i = 0; i <= lastIx; i++) begin
      if (mode32 || (i % 4 != 3)) begin
        expBytes.push_back(shadow[i]);
      end
    end
  endtask

  task automatic waitIdle();
    byteT state;
    int   tries;
    tries = 0;
    state = 8'h01;
    while (state[0] !== 1'b0 && tries < 1000) begin
      readBus(regAddr(REG_STATE), state);
      tries++;
    end
    checks++;
    assert (state[0] === 1'b0) else begin
      errors++;
      $display("Timeout waiting for the sequencer to go idle");
    end
  endtask

  // measures high pulses on neoData and ends at the latch gap
  task automatic decodeFrame();
    int   waitCnt;
    int   highCnt;
    int   lowCnt;
    int   bitCnt;
    int   bitTotal;
    byteT cur;
    gotBytes.delete();
    waitCnt = 0;
    while (neoData !== 1'b1 && waitCnt < WAIT_LIMIT) begin
      @(negedge busClk);
      waitCnt++;
    end
    checks++;
    assert (waitCnt < WAIT_LIMIT) else begin
      errors++;
      $display("Timeout waiting for the first pulse of a frame");
    end
    if (waitCnt >= WAIT_LIMIT) return;
    lowCnt   = 0;
    bitCnt   = 0;
    bitTotal = 0;
    cur      = '0;
    while (lowCnt < T_LATCH && bitTotal < 8 * (BUFFER_END + 2)) begin
      highCnt = 0;
      while (neoData === 1'b1 && highCnt <= T1_HIGH) begin
        highCnt++;
        @(negedge busClk);
      end
      checks++;
      assert (highCnt == T0_HIGH || highCnt == T1_HIGH) else begin
        errors++;
        $display("Pulse of %0d cycles is neither a zero nor a one", highCnt);
      end
      cur = {cur[6:0], highCnt == T1_HIGH};
      bitCnt++;
      bitTotal++;
      if (bitCnt == 8) begin
        gotBytes.push_back(cur);
        bitCnt = 0;
      end
      lowCnt = 0;
      while (neoData !== 1'b1 && lowCnt < T_LATCH) begin
        lowCnt++;
        @(negedge busClk);
      end
    end
    checkValue("leftover bits", bitCnt, 0);
  endtask

  task automatic compareFrame(const ref byteT exp [$]);
    checkValue("decoded length", gotBytes.size(), exp.size());
    for (int i = 0; i < gotBytes.size() && i < exp.size(); i++) begin
      checkValue($sformatf("neoData byte %0d", i), gotBytes[i], exp[i]);
    end
  endtask

  task automatic testRegisters();
    writeBus(regAddr(REG_MAX_LO), 8'hA5);
    writeBus(regAddr(REG_MAX_HI), 8'hE3);
    // bit 2 clear so that no frame starts
    writeBus(regAddr(REG_CTRL), 8'hFA);
    readCheck(regAddr(REG_MAX_LO), 8'hA5, "REG_MAX_LO");
    readCheck(regAddr(REG_MAX_HI), 8'hE3 & 8'h1F, "REG_MAX_HI");
    readCheck(regAddr(REG_CTRL), 8'hFA & 8'h1F, "REG_CTRL");
    readCheck(14'h0010, 8'hFF, "buffer read");
    writeBus(regAddr(REG_CTRL), 8'h00);
  endtask

  task automatic testLimitedFrame();
    loadBuffer(16);
    writeBus(regAddr(REG_MAX_LO), 8'd11);
    writeBus(regAddr(REG_MAX_HI), 8'd0);
    buildExpected(11, 1'b1);
    writeBus(regAddr(REG_CTRL), 8'h16);
    fork
      decodeFrame();
      begin
        repeat (20) @(negedge busClk);
        readCheck(regAddr(REG_STATE), 8'h01, "REG_STATE during frame");
      end
    join
    compareFrame(expBytes);
    waitIdle();
    readCheck(regAddr(REG_STATE), 8'h00, "REG_STATE after frame");
    readCheck(regAddr(REG_CTRL), 8'h12, "REG_CTRL after frame");
  endtask

  task automatic testMode24();
    buildExpected(11, 1'b0);
    writeBus(regAddr(REG_CTRL), 8'h06);
    decodeFrame();
    compareFrame(expBytes);
    waitIdle();
  endtask

  task automatic testLoopSync();
    int quietStart;
    buildExpected(11, 1'b1);
    writeBus(regAddr(REG_CTRL), 8'h1E);
    decodeFrame();
    firstFrame = gotBytes;
    compareFrame(expBytes);
    decodeFrame();
    compareFrame(firstFrame);
    readCheck(regAddr(REG_CTRL), 8'h1E, "REG_CTRL while looping");
    writeBus(regAddr(REG_CTRL), 8'h12);
    waitIdle();
    @(negedge busClk);
    syncStart = 1'b1;
    @(negedge busClk);
    syncStart = 1'b0;
    decodeFrame();
    compareFrame(expBytes);
    waitIdle();
    // no second frame may follow without loop
    quietStart = highSeen;
    repeat (80) @(negedge busClk);
    checkValue("high cycles after single frame", highSeen - quietStart, 0);
    readCheck(regAddr(REG_CTRL), 8'h12, "REG_CTRL after syncStart frame");
  endtask

  task automatic testInit();
    int   startHigh;
    int   tries;
    byteT ctrlVal;
    startHigh = highSeen;
    writeBus(regAddr(REG_CTRL), 8'h1F);
    tries   = 0;
    ctrlVal = 8'h1F;
    while (ctrlVal !== 8'h00 && tries < 200) begin
      readBus(regAddr(REG_CTRL), ctrlVal);
      tries++;
    end
    checkValue("REG_CTRL after init", ctrlVal, 8'h00);
    checkValue("high cycles during init", highSeen - startHigh, 0);
    readCheck(regAddr(REG_STATE), 8'h00, "REG_STATE after init");
  endtask

  initial begin
    rstN      = 1'b0;
    busAddr   = '0;
    busDataIn = '0;
    busWrite  = 1'b0;
    busRead   = 1'b0;
    syncStart = 1'b0;
    errors    = 0;
    checks    = 0;
    highSeen  = 0;
    lfsr      = 32'he1b8;
    repeat (4) @(negedge busClk);
    rstN = 1'b1;
    testRegisters();
    testLimitedFrame();
    testMode24();
    testLoopSync();
    testInit();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: list.f
logic/neoPkg.sv
logic/neoPixelRam.sv
logic/neoRegisters.sv
logic/neoFrameSequencer.sv
logic/neoBitEncoder.sv
logic/neoTop.sv
verif/neoTb.sv

// File: Bender.yml
package:
  name: neo_pixel

sources:
  - logic/neoPkg.sv
  - logic/neoPixelRam.sv
  - logic/neoRegisters.sv
  - logic/neoFrameSequencer.sv
  - logic/neoBitEncoder.sv
  - logic/neoTop.sv
  - target: test
    files:
      - verif/neoTb.sv
